// File: Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - source
    files:
      - source/rv_exec_pkg.sv
      - source/apb_inst_port.sv
      - source/id_stage.sv
      - source/ex_stage.sv
      - source/wb_stage.sv
      - source/rv_exec_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/rv_exec_properties.sv
      - tb/tb_rv_exec.sv

// File: flist.f
+incdir+source
source/rv_exec_pkg.sv
source/apb_inst_port.sv
source/id_stage.sv
source/ex_stage.sv
source/wb_stage.sv
source/rv_exec_top.sv
tb/rv_exec_properties.sv
tb/tb_rv_exec.sv

// File: source/apb_inst_port.sv
// APB3 slave; one instruction in flight, high halves are staged until the low write
`include "rv_exec_consts.svh"

module apb_inst_port
	import rv_exec_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [`APB_AW-1:0] paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_DW-1:0] pwdata,
	output logic [`APB_DW-1:0] prdata,
	output logic               pready,
	output logic               pslverr,
	input  logic               done,
	input  logic               illegal,
	input  logic [`XLEN-1:0]   host_reg_rdata,
	input  logic [`XLEN-1:0]   pc,
	input  logic [`APB_DW-1:0] illegal_count,
	output logic               inst_valid,
	output inst_u              inst,
	output logic               host_reg_we,
	output logic [4:0]         host_reg_addr,
	output logic [`XLEN-1:0]   host_wdata,
	output logic               host_pc_we
);

	logic access;
	logic a_inst, a_pc_lo, a_pc_hi, a_ill, a_xreg;
	logic inst_wr;
	logic mapped;
	logic busy;
	logic [`APB_DW-1:0] stage_hi;

	assign access = psel & penable;

	// address map
	assign a_inst  = paddr == `ADDR_INST;
	assign a_pc_lo = paddr == `ADDR_PC_LO;
	assign a_pc_hi = paddr == `ADDR_PC_HI;
	assign a_ill   = paddr == `ADDR_ILLEGAL;
	assign a_xreg  = ({paddr[11:8], 8'h00} == `ADDR_XREG_BASE) && (paddr[1:0] == 2'b00);
	assign inst_wr = a_inst & pwrite;
	assign mapped  = inst_wr | a_pc_lo | a_pc_hi | a_xreg | (a_ill & ~pwrite);

	// launch only in the first access cycle
	assign inst_valid = access & inst_wr & ~busy;
	assign inst       = pwdata;

	assign host_reg_addr = paddr[7:3];
	assign host_wdata    = {stage_hi, pwdata};
	assign host_reg_we   = access & pwrite & a_xreg & ~paddr[2];
	assign host_pc_we    = access & pwrite & a_pc_lo;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			stage_hi <= '0;
		end else begin
			if (inst_valid) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
			// high half waits for the matching low write
			if (access && pwrite && ((a_xreg && paddr[2]) || a_pc_hi)) begin
				stage_hi <= pwdata;
			end
		end
	end

	// instruction writes stall until the result stage is done
	assign pready  = access & (inst_wr ? (busy & done) : 1'b1);
	assign pslverr = access & (inst_wr ? (busy & done & illegal) : ~mapped);

	always_comb begin
		prdata = '0;
		if (a_pc_lo) begin
			prdata = pc[31:0];
		end else if (a_pc_hi) begin
			prdata = pc[`XLEN-1:32];
		end else if (a_ill) begin
			prdata = illegal_count;
		end else if (a_xreg) begin
			prdata = paddr[2] ? host_reg_rdata[`XLEN-1:32] : host_reg_rdata[31:0];
		end
	end

endmodule

// File: source/ex_stage.sv
// single-cycle RV64I ALU and next-PC logic; no misalignment check on jump targets
`include "rv_exec_consts.svh"

module ex_stage
	import rv_exec_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             dec_valid,
	input  logic             rd_w_ena,
	input  logic [4:0]       rd_w_addr,
	input  alu_op_e          alu_op,
	input  logic [`XLEN-1:0] imm,
	input  op1_src_e         alu_op1_src,
	input  op2_src_e         alu_op2_src,
	input  logic             branch,
	input  logic             jump,
	input  logic             pc_src,
	input  logic             illegal,
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	input  logic [`XLEN-1:0] pc,
	output logic             ex_valid,
	output logic [`XLEN-1:0] result,
	output logic             rd_w_ena_q,
	output logic [4:0]       rd_w_addr_q,
	output logic [`XLEN-1:0] next_pc,
	output logic             illegal_q
);

	logic [`XLEN-1:0] op1, op2, alu_res, npc;
	logic taken;

	// W forms keep 32 bits and sign-extend
	function automatic logic [`XLEN-1:0] sext_w(input logic [31:0] w);
		return {{(`XLEN-32){w[31]}}, w};
	endfunction

	assign op1 = (alu_op1_src == OP1_PC) ? pc : rs1_data;

	always_comb begin
		case (alu_op2_src)
			OP2_IMM: op2 = imm;
			OP2_4:   op2 = `XLEN'(4);
			default: op2 = rs2_data;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_ADD:  alu_res = op1 + op2;
			ALU_SUB:  alu_res = op1 - op2;
			ALU_SLL:  alu_res = op1 << op2[5:0];
			ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
			ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, op1 < op2};
			ALU_XOR:  alu_res = op1 ^ op2;
			ALU_SRL:  alu_res = op1 >> op2[5:0];
			ALU_SRA:  alu_res = $signed(op1) >>> op2[5:0];
			ALU_OR:   alu_res = op1 | op2;
			ALU_AND:  alu_res = op1 & op2;
			ALU_ADDW: alu_res = sext_w(op1[31:0] + op2[31:0]);
			ALU_SUBW: alu_res = sext_w(op1[31:0] - op2[31:0]);
			ALU_SLLW: alu_res = sext_w(op1[31:0] << op2[4:0]);
			ALU_SRLW: alu_res = sext_w(op1[31:0] >> op2[4:0]);
			ALU_SRAW: alu_res = sext_w($signed(op1[31:0]) >>> op2[4:0]);
			ALU_LUI:  alu_res = op2;
			default:  alu_res = '0;
		endcase
	end

	// branch compare on rs1 and rs2
	always_comb begin
		case (alu_op)
			ALU_BEQ:  taken = op1 == op2;
			ALU_BNE:  taken = op1 != op2;
			ALU_BLT:  taken = $signed(op1) < $signed(op2);
			ALU_BGE:  taken = $signed(op1) >= $signed(op2);
			ALU_BLTU: taken = op1 < op2;
			ALU_BGEU: taken = op1 >= op2;
			default:  taken = 1'b0;
		endcase
	end

	always_comb begin
		if (illegal) begin
			npc = pc;
		end else if (jump && pc_src) begin
			// jalr target drops bit 0
			npc = (rs1_data + imm) & ~`XLEN'(1);
		end else if ((branch && taken) || jump) begin
			npc = pc + imm;
		end else begin
			npc = pc + `XLEN'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid   <= 1'b0;
			rd_w_ena_q <= 1'b0;
			illegal_q  <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
			// illegal_q holds until the next instruction for the apb response
			if (dec_valid) begin
				rd_w_ena_q <= rd_w_ena;
				illegal_q  <= illegal;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			result      <= alu_res;
			rd_w_addr_q <= rd_w_addr;
			next_pc     <= npc;
		end
	end

endmodule

// File: source/id_stage.sv
// decodes OP, OP-IMM, W forms, LUI, AUIPC, JAL, JALR and branches; all else is illegal
`include "rv_exec_consts.svh"

module id_stage
	import rv_exec_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             inst_valid,
	input  inst_u            inst,
	output logic             dec_valid,
	output logic [4:0]       rs1_r_addr,
	output logic [4:0]       rs2_r_addr,
	output logic             rd_w_ena,
	output logic [4:0]       rd_w_addr,
	output alu_op_e          alu_op,
	output logic [`XLEN-1:0] imm,
	output op1_src_e         alu_op1_src,
	output op2_src_e         alu_op2_src,
	output logic             branch,
	output logic             jump,
	output logic             pc_src,
	output logic             illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;
	logic [`XLEN-1:0] imm_i, imm_b, imm_u, imm_j;

	logic d_rd_w_ena, d_branch, d_jump, d_pc_src, d_illegal;
	alu_op_e d_alu_op;
	logic [`XLEN-1:0] d_imm;
	op1_src_e d_op1;
	op2_src_e d_op2;

	assign opcode = inst.r.opcode;
	assign funct3 = inst.r.funct3;
	// inst[30] picks sub and arithmetic shift
	assign alt = inst.r.funct7[5];

	assign imm_i = {{(`XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
	assign imm_b = {{(`XLEN-12){inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
		inst.b.imm_4_1, 1'b0};
	assign imm_u = {{(`XLEN-32){inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'b0};
	assign imm_j = {{(`XLEN-20){inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
		inst.j.imm_10_1, 1'b0};

	always_comb begin
		d_rd_w_ena = 1'b0;
		d_branch   = 1'b0;
		d_jump     = 1'b0;
		d_pc_src   = 1'b0;
		d_illegal  = 1'b0;
		d_alu_op   = ALU_ZERO;
		d_imm      = '0;
		d_op1      = OP1_REG;
		d_op2      = OP2_REG;
		case (opcode)
			`OPC_OP_IMM, `OPC_OP: begin
				d_rd_w_ena = 1'b1;
				d_op2      = (opcode == `OPC_OP_IMM) ? OP2_IMM : OP2_REG;
				d_imm      = imm_i;
				case (funct3)
					`F3_ADD:  d_alu_op = (opcode == `OPC_OP && alt) ? ALU_SUB : ALU_ADD;
					`F3_SL:   d_alu_op = ALU_SLL;
					`F3_SLT:  d_alu_op = ALU_SLT;
					`F3_SLTU: d_alu_op = ALU_SLTU;
					`F3_XOR:  d_alu_op = ALU_XOR;
					`F3_SR:   d_alu_op = alt ? ALU_SRA : ALU_SRL;
					`F3_OR:   d_alu_op = ALU_OR;
					`F3_AND:  d_alu_op = ALU_AND;
				endcase
			end
			`OPC_OP_IMM_32, `OPC_OP_32: begin
				d_rd_w_ena = 1'b1;
				d_op2      = (opcode == `OPC_OP_IMM_32) ? OP2_IMM : OP2_REG;
				d_imm      = imm_i;
				case (funct3)
					`F3_ADD: d_alu_op = (opcode == `OPC_OP_32 && alt) ? ALU_SUBW : ALU_ADDW;
					`F3_SL:  d_alu_op = ALU_SLLW;
					`F3_SR:  d_alu_op = alt ? ALU_SRAW : ALU_SRLW;
					default: d_illegal = 1'b1;
				endcase
			end
			`OPC_LUI: begin
				d_rd_w_ena = 1'b1;
				d_op2      = OP2_IMM;
				d_imm      = imm_u;
				d_alu_op   = ALU_LUI;
			end
			`OPC_AUIPC: begin
				d_rd_w_ena = 1'b1;
				d_op1      = OP1_PC;
				d_op2      = OP2_IMM;
				d_imm      = imm_u;
				d_alu_op   = ALU_ADD;
			end
			`OPC_JAL, `OPC_JALR: begin
				// link value pc + 4 through the alu, target built in execute
				d_rd_w_ena = 1'b1;
				d_jump     = 1'b1;
				d_pc_src   = opcode == `OPC_JALR;
				d_op1      = OP1_PC;
				d_op2      = OP2_4;
				d_imm      = (opcode == `OPC_JALR) ? imm_i : imm_j;
				d_alu_op   = ALU_ADD;
				d_illegal  = (opcode == `OPC_JALR) && (funct3 != `F3_JALR);
			end
			`OPC_BRANCH: begin
				d_branch = 1'b1;
				d_imm    = imm_b;
				case (funct3)
					`F3_BEQ:  d_alu_op = ALU_BEQ;
					`F3_BNE:  d_alu_op = ALU_BNE;
					`F3_BLT:  d_alu_op = ALU_BLT;
					`F3_BGE:  d_alu_op = ALU_BGE;
					`F3_BLTU: d_alu_op = ALU_BLTU;
					`F3_BGEU: d_alu_op = ALU_BGEU;
					default:  d_illegal = 1'b1;
				endcase
			end
			default: d_illegal = 1'b1;
		endcase
	end

	// illegal words leave every enable low
	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
			rd_w_ena  <= 1'b0;
			branch    <= 1'b0;
			jump      <= 1'b0;
			pc_src    <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			dec_valid <= inst_valid;
			if (inst_valid) begin
				rd_w_ena <= d_rd_w_ena & ~d_illegal;
				branch   <= d_branch & ~d_illegal;
				jump     <= d_jump & ~d_illegal;
				pc_src   <= d_pc_src & ~d_illegal;
				illegal  <= d_illegal;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid) begin
			rs1_r_addr  <= inst.r.rs1;
			rs2_r_addr  <= inst.r.rs2;
			rd_w_addr   <= inst.r.rd;
			alu_op      <= d_alu_op;
			imm         <= d_imm;
			alu_op1_src <= d_op1;
			alu_op2_src <= d_op2;
		end
	end

endmodule

// File: source/rv_exec_consts.svh
// RV64I base encodings only; the APB map decodes 12 address bits, word aligned
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

`define XLEN   64
`define APB_AW 12
`define APB_DW 32

// major opcodes kept by the slice
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP        7'b0110011
`define OPC_OP_32     7'b0111011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011

// funct3 for OP, OP-IMM and the W forms
`define F3_ADD  3'b000
`define F3_SL   3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// funct3 for branches and jalr
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111
`define F3_JALR 3'b000

// apb address map, register i at base + 8*i
`define ADDR_INST      12'h000
`define ADDR_PC_LO     12'h008
`define ADDR_PC_HI     12'h00C
`define ADDR_ILLEGAL   12'h010
`define ADDR_XREG_BASE 12'h100

`endif

// File: source/rv_exec_pkg.sv
// 32-bit instruction formats only; compressed encodings are not described
package rv_exec_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_i_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} inst_s_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} inst_b_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_u_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_j_t;

	// one instruction word, seen through each format
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
		inst_s_t s;
		inst_b_t b;
		inst_u_t u;
		inst_j_t j;
	} inst_u;

	typedef enum logic [4:0] {
		ALU_ZERO, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
		ALU_SRA, ALU_OR, ALU_AND, ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
		ALU_LUI, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	typedef enum logic {
		OP1_REG,
		OP1_PC
	} op1_src_e;

	typedef enum logic [1:0] {
		OP2_REG,
		OP2_IMM,
		OP2_4
	} op2_src_e;

endpackage

// File: source/rv_exec_top.sv
// APB-driven RV64I slice; an instruction write holds the bus for four access cycles
`include "rv_exec_consts.svh"

module rv_exec_top
	import rv_exec_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [`APB_AW-1:0] paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_DW-1:0] pwdata,
	output logic [`APB_DW-1:0] prdata,
	output logic               pready,
	output logic               pslverr
);

	// host side
	logic inst_valid, host_reg_we, host_pc_we, done;
	inst_u inst;
	logic [4:0] host_reg_addr;
	logic [`XLEN-1:0] host_wdata, host_reg_rdata, pc;
	logic [`APB_DW-1:0] illegal_count;

	// decode to execute
	logic dec_valid, rd_w_ena, branch, jump, pc_src, illegal;
	logic [4:0] rs1_r_addr, rs2_r_addr, rd_w_addr;
	alu_op_e alu_op;
	logic [`XLEN-1:0] imm, rs1_data, rs2_data;
	op1_src_e alu_op1_src;
	op2_src_e alu_op2_src;

	// execute to writeback
	logic ex_valid, rd_w_ena_q, illegal_q;
	logic [4:0] rd_w_addr_q;
	logic [`XLEN-1:0] result, next_pc;

	apb_inst_port i_apb_port (
		.illegal (illegal_q),
		.*
	);

	id_stage i_id_stage (.*);

	ex_stage i_ex_stage (.*);

	wb_stage i_wb_stage (
		.rd_w_ena  (rd_w_ena_q),
		.rd_w_addr (rd_w_addr_q),
		.illegal   (illegal_q),
		.*
	);

endmodule

// File: source/wb_stage.sv
// x0 reads zero; host writes are ignored while a result is being committed
`include "rv_exec_consts.svh"

module wb_stage (
	input  logic               clk,
	input  logic               rst,
	input  logic               ex_valid,
	input  logic [`XLEN-1:0]   result,
	input  logic               rd_w_ena,
	input  logic [4:0]         rd_w_addr,
	input  logic [`XLEN-1:0]   next_pc,
	input  logic               illegal,
	input  logic [4:0]         rs1_r_addr,
	input  logic [4:0]         rs2_r_addr,
	input  logic               host_reg_we,
	input  logic [4:0]         host_reg_addr,
	input  logic [`XLEN-1:0]   host_wdata,
	input  logic               host_pc_we,
	output logic [`XLEN-1:0]   rs1_data,
	output logic [`XLEN-1:0]   rs2_data,
	output logic [`XLEN-1:0]   host_reg_rdata,
	output logic [`XLEN-1:0]   pc,
	output logic [`APB_DW-1:0] illegal_count,
	output logic               done
);

	logic [`XLEN-1:0] xreg [1:31];

	assign rs1_data       = (rs1_r_addr == 5'd0) ? '0 : xreg[rs1_r_addr];
	assign rs2_data       = (rs2_r_addr == 5'd0) ? '0 : xreg[rs2_r_addr];
	assign host_reg_rdata = (host_reg_addr == 5'd0) ? '0 : xreg[host_reg_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				xreg[i] <= '0;
			end
			pc            <= '0;
			illegal_count <= '0;
			done          <= 1'b0;
		end else begin
			done <= ex_valid;
			if (ex_valid) begin
				if (rd_w_ena && rd_w_addr != 5'd0) begin
					xreg[rd_w_addr] <= result;
				end
				pc <= next_pc;
				if (illegal) begin
					illegal_count <= illegal_count + 1'b1;
				end
			end else begin
				// host side, x0 stays zero
				if (host_reg_we && host_reg_addr != 5'd0) begin
					xreg[host_reg_addr] <= host_wdata;
				end
				if (host_pc_we) begin
					pc <= host_wdata;
				end
			end
		end
	end

endmodule

// File: tb/rv_exec_properties.sv
// APB protocol and writeback timing checks, bound into every rv_exec_top
`include "rv_exec_consts.svh"

module rv_exec_properties (
	input logic               clk,
	input logic               rst,
	input logic [`APB_AW-1:0] paddr,
	input logic               psel,
	input logic               penable,
	input logic               pwrite,
	input logic               pready,
	input logic               done
);
	timeunit 1ns;
	timeprecision 100ps;

	// pready only inside an access phase
	assert property (@(posedge clk) disable iff (rst) pready |-> (psel && penable))
		else $error("pready high outside an access phase");

	// instruction write holds the bus for exactly four access cycles
	assert property (@(posedge clk) disable iff (rst)
		(psel && !penable && pwrite && paddr == `ADDR_INST) ##1 (psel && penable)
		|-> !pready [*3] ##1 pready)
		else $error("instruction write did not complete in four access cycles");

	assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done held longer than one cycle");

endmodule

bind rv_exec_top rv_exec_properties i_props (
	.clk     (clk),
	.rst     (rst),
	.paddr   (paddr),
	.psel    (psel),
	.penable (penable),
	.pwrite  (pwrite),
	.pready  (pready),
	.done    (done)
);

// File: tb/tb_rv_exec.sv
// directed tests over APB; stops at the first mismatch, pc and x1..x9 are the working set
`include "rv_exec_consts.svh"

module tb_rv_exec;
	timeunit 1ns;
	timeprecision 100ps;

	// cycle budget for each directed test
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 200;

	logic clk;
	logic rst;
	logic [`APB_AW-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_DW-1:0] pwdata;
	logic [`APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;

	int seed = 32'hb0f1;
	logic [`XLEN-1:0] model [0:31];
	logic [`XLEN-1:0] pc_m;
	logic [`APB_DW-1:0] ill_m;

	rv_exec_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$fatal(1, "simulation timed out");
	end

	task automatic check_reg(input string name, input logic [`XLEN-1:0] exp,
		input logic [`XLEN-1:0] act);
		if (exp !== act) begin
			$display("Error: %s register expected %h actual %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "register mismatch");
		end
	endtask

	task automatic check_pc(input string name, input logic [`XLEN-1:0] exp,
		input logic [`XLEN-1:0] act);
		if (exp !== act) begin
			$display("Error: %s pc expected %h actual %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "pc mismatch");
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Error: %s pslverr expected %b actual %b", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "pslverr mismatch");
		end
	endtask

	task automatic check_count(input string name, input logic [`APB_DW-1:0] exp,
		input logic [`APB_DW-1:0] act);
		if (exp !== act) begin
			$display("Error: %s illegal count expected %h actual %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "illegal count mismatch");
		end
	endtask

	// one APB transfer, setup then access until pready
	task automatic apb_xfer(input logic [`APB_AW-1:0] addr, input logic wr,
		input logic [`APB_DW-1:0] wdata, output logic [`APB_DW-1:0] rdata, output logic err);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		paddr   = addr;
		pwrite  = wr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		do @(negedge clk); while (!pready);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data,
		output logic err);
		logic [`APB_DW-1:0] unused;
		apb_xfer(addr, 1'b1, data, unused, err);
	endtask

	task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [`APB_DW-1:0] data,
		output logic err);
		apb_xfer(addr, 1'b0, '0, data, err);
	endtask

	function automatic logic [`XLEN-1:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [`APB_AW-1:0] reg_addr(input int idx);
		return `ADDR_XREG_BASE + `APB_AW'(8 * idx);
	endfunction

	task automatic set_reg(input int idx, input logic [`XLEN-1:0] val);
		logic err;
		apb_write(reg_addr(idx) + 4, val[63:32], err);
		apb_write(reg_addr(idx), val[31:0], err);
		if (idx != 0) model[idx] = val;
	endtask

	task automatic get_reg(input int idx, output logic [`XLEN-1:0] val);
		logic err;
		apb_read(reg_addr(idx), val[31:0], err);
		apb_read(reg_addr(idx) + 4, val[63:32], err);
	endtask

	task automatic set_pc(input logic [`XLEN-1:0] val);
		logic err;
		apb_write(`ADDR_PC_HI, val[63:32], err);
		apb_write(`ADDR_PC_LO, val[31:0], err);
		pc_m = val;
	endtask

	task automatic get_pc(output logic [`XLEN-1:0] val);
		logic err;
		apb_read(`ADDR_PC_LO, val[31:0], err);
		apb_read(`ADDR_PC_HI, val[63:32], err);
	endtask

	task automatic run_inst(input string name, input logic [31:0] word, input logic exp_err);
		logic err;
		apb_write(`ADDR_INST, word, err);
		check_err(name, exp_err, err);
	endtask

	task automatic verify(input string name, input int rd);
		logic [`XLEN-1:0] v;
		get_reg(rd, v);
		check_reg(name, model[rd], v);
		get_pc(v);
		check_pc(name, pc_m, v);
	endtask

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
	endfunction

	// RV64I integer results straight from the ISA rules
	function automatic logic [`XLEN-1:0] ref_op(input logic [2:0] f3, input bit alt,
		input bit w, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic [31:0] r32;
		logic [`XLEN-1:0] r;
		r32 = '0;
		r = '0;
		if (!w) begin
			case (f3)
				3'd0: r = alt ? a - b : a + b;
				3'd1: r = a << b[5:0];
				3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
				3'd3: r = (a < b) ? 64'd1 : 64'd0;
				3'd4: r = a ^ b;
				3'd5: begin
					if (alt) begin
						r = $signed(a) >>> b[5:0];
					end else begin
						r = a >> b[5:0];
					end
				end
				3'd6: r = a | b;
				default: r = a & b;
			endcase
		end else begin
			case (f3)
				3'd0: r32 = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
				3'd1: r32 = a[31:0] << b[4:0];
				default: begin
					if (alt) begin
						r32 = $signed(a[31:0]) >>> b[4:0];
					end else begin
						r32 = a[31:0] >> b[4:0];
					end
				end
			endcase
			r = {{32{r32[31]}}, r32};
		end
		return r;
	endfunction

	task automatic test_reg_access();
		logic [`XLEN-1:0] v;
		logic [`APB_DW-1:0] d;
		logic err;
		for (int i = 1; i < 32; i += 10) begin
			set_reg(i, rand64());
			get_reg(i, v);
			check_reg("reg_access", model[i], v);
		end
		set_reg(0, 64'hdead_beef_0123_4567);
		get_reg(0, v);
		check_reg("reg_access", '0, v);
		apb_read(12'h020, d, err);
		check_err("reg_access", 1'b1, err);
		apb_write(12'h018, 32'h1234, err);
		check_err("reg_access", 1'b1, err);
	endtask

	task automatic test_alu(input bit w);
		string name;
		logic [6:0] opc_r, opc_i;
		logic [11:0] i12;
		bit alt;
		name  = w ? "w_forms" : "alu_ops";
		opc_r = w ? `OPC_OP_32 : `OPC_OP;
		opc_i = w ? `OPC_OP_IMM_32 : `OPC_OP_IMM;
		set_reg(1, rand64());
		set_reg(2, rand64());
		set_pc(64'h1000);
		for (int f = 0; f < 8; f++) begin
			for (int k = 0; k < 2; k++) begin
				alt = k;
				if (w && !(f == 0 || f == 1 || f == 5)) continue;
				if (alt && !(f == 0 || f == 5)) continue;
				model[3] = ref_op(f, alt, w, model[1], model[2]);
				run_inst(name, enc_r(alt ? 7'h20 : 7'h00, 2, 1, f, 3, opc_r), 1'b0);
				pc_m += 4;
				verify(name, 3);
				// no immediate subtract
				if (f == 0 && alt) continue;
				i12 = $random(seed);
				if (f == 1 || f == 5) begin
					i12[11:6] = alt ? 6'b010000 : 6'b000000;
					if (w) i12[5] = 1'b0;
				end
				model[4] = ref_op(f, alt, w, model[1], {{52{i12[11]}}, i12});
				run_inst(name, enc_i(i12, 1, f, 4, opc_i), 1'b0);
				pc_m += 4;
				verify(name, 4);
			end
		end
	endtask

	task automatic test_upper_jump();
		set_pc(64'h0010_0000);
		model[7] = {{32{1'b1}}, 20'hfedcb, 12'h000};
		run_inst("lui", {20'hfedcb, 5'd7, `OPC_LUI}, 1'b0);
		pc_m += 4;
		verify("lui", 7);
		model[7] = pc_m + {{32{1'b1}}, 20'h80001, 12'h000};
		run_inst("auipc", {20'h80001, 5'd7, `OPC_AUIPC}, 1'b0);
		pc_m += 4;
		verify("auipc", 7);
		model[8] = pc_m + 4;
		run_inst("jal", enc_j(21'h1ffff0, 8), 1'b0);
		pc_m -= 16;
		verify("jal", 8);
		set_reg(1, 64'h2001);
		model[9] = pc_m + 4;
		run_inst("jalr", enc_i(12'd6, 1, `F3_JALR, 9, `OPC_JALR), 1'b0);
		pc_m = (model[1] + 6) & ~64'd1;
		verify("jalr", 9);
	endtask

	task automatic test_branches();
		logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [`XLEN-1:0] av [3] = '{64'd5, '1, 64'd1};
		logic [`XLEN-1:0] bv [3] = '{64'd5, 64'd1, '1};
		logic [`XLEN-1:0] v;
		bit taken;
		set_pc(64'h4000);
		for (int p = 0; p < 3; p++) begin
			set_reg(1, av[p]);
			set_reg(2, bv[p]);
			foreach (f3s[k]) begin
				case (f3s[k])
					3'd0: taken = av[p] == bv[p];
					3'd1: taken = av[p] != bv[p];
					3'd4: taken = $signed(av[p]) < $signed(bv[p]);
					3'd5: taken = $signed(av[p]) >= $signed(bv[p]);
					3'd6: taken = av[p] < bv[p];
					default: taken = av[p] >= bv[p];
				endcase
				run_inst("branch", enc_b(13'd24, 2, 1, f3s[k]), 1'b0);
				pc_m += taken ? 64'd24 : 64'd4;
				get_pc(v);
				check_pc("branch", pc_m, v);
			end
		end
	endtask

	task automatic test_illegal();
		logic [`APB_DW-1:0] d;
		logic err;
		set_pc(64'h3000);
		// nonzero contents so a stray write would show
		set_reg(5, rand64());
		set_reg(8, rand64());
		run_inst("illegal", enc_i(12'h10, 1, 3'b011, 5, 7'b0000011), 1'b1);
		ill_m++;
		verify("illegal", 5);
		apb_read(`ADDR_ILLEGAL, d, err);
		check_count("illegal", ill_m, d);
		run_inst("illegal", {7'd0, 5'd2, 5'd1, 3'b011, 5'd8, 7'b0100011}, 1'b1);
		ill_m++;
		verify("illegal", 8);
		apb_read(`ADDR_ILLEGAL, d, err);
		check_count("illegal", ill_m, d);
	endtask

	initial begin
		rst     = 1'b1;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		pc_m    = '0;
		ill_m   = '0;
		foreach (model[i]) model[i] = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reg_access();
		test_alu(1'b0);
		test_alu(1'b1);
		test_upper_jump();
		test_branches();
		test_illegal();
		$display("TESTS PASSED");
		$finish;
	end

endmodule
